//--- rtl/tcb_defs.svh
/* TCB memory subsystem parameters
   bus widths, response latency, bank layout and refresh period */

`ifndef TCB_DEFS_SVH
`define TCB_DEFS_SVH

// byte address width
`define TCB_ABW 16
// data width and byte enables
`define TCB_DBW 32
`define TCB_BEW 4

// fixed response latency in cycles
`define TCB_DLY 2

// bank layout, select sits above the word offset
`define TCB_BANK_N 4
`define TCB_BANK_SEL_LSB 12
`define TCB_MEM_DEPTH 64

// refresh stall period in cycles
`define TCB_REFRESH 16

`endif

//--- rtl/tcb_pkg.sv
/* TCB memory subsystem types
   address, data, byte enable, bank select, bank state and opcode */

`include "tcb_defs.svh"

package tcb_pkg;

  ////////////////////
  // bus payload
  ////////////////////

  // byte address
  typedef logic [`TCB_ABW-1:0] tcb_adr_t;
  // data word
  typedef logic [`TCB_DBW-1:0] tcb_dat_t;
  // one enable per byte lane
  typedef logic [`TCB_BEW-1:0] tcb_ben_t;

  // bank index
  typedef logic [$clog2(`TCB_BANK_N)-1:0] bank_sel_t;

  ////////////////////
  // enums
  ////////////////////

  // refresh fsm
  typedef enum logic {
    bank_run     = 1'b0,
    bank_refresh = 1'b1
  } bank_state_t;

  // opcode, travels on the wen line
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } tcb_op_t;

endpackage

//--- rtl/tcb_if.sv
/* TCB bus interface
   request, ready and fixed latency response with transfer strobe */

`timescale 1ns/1ps

`include "tcb_defs.svh"

interface tcb_if;

  import tcb_pkg::*;

  // request, from manager
  logic     vld;
  tcb_op_t  op;
  tcb_adr_t adr;
  tcb_ben_t ben;
  tcb_dat_t wdt;
  // handshake, from subordinate
  logic     rdy;
  // response, from subordinate
  logic     rsp;
  tcb_dat_t rdt;
  logic     err;

  // transfer strobe
  logic     trn;

  assign trn = vld & rdy;

  // decoder side
  modport man (
    output vld, op, adr, ben, wdt,
    input  rdy, rsp, rdt, err, trn
  );

  // bank side
  modport sub (
    input  vld, op, adr, ben, wdt, trn,
    output rdy, rsp, rdt, err
  );

  // response mux only observes
  modport mon (
    input  vld, op, adr, ben, wdt, rdy, rsp, rdt, err, trn
  );

endinterface

//--- rtl/tcb_dec.sv
/* TCB address decoder
   routes one manager request to a bank and returns that bank's rdy */

`timescale 1ns/1ps

`include "tcb_defs.svh"

module tcb_dec (
  input  logic                tcb,
  input  logic                rst_n,
  // manager request
  input  logic                vld,
  input  tcb_pkg::tcb_op_t    op,
  input  tcb_pkg::tcb_adr_t   adr,
  input  tcb_pkg::tcb_ben_t   ben,
  input  tcb_pkg::tcb_dat_t   wdt,
  output logic                rdy,
  // select toward response mux
  output tcb_pkg::bank_sel_t  bank_sel,
  // bank ports
  tcb_if.man                  bank [`TCB_BANK_N]
);

  import tcb_pkg::*;

  ////////////////////
  // bank select
  ////////////////////

  // index straight from the address, upper bits alias
  bank_sel_t adr_sel;
  // select locked while a request waits out a stall
  logic      hold;
  bank_sel_t hold_sel;
  // per bank ready
  logic [`TCB_BANK_N-1:0] rdy_a;

  assign adr_sel = adr[`TCB_BANK_SEL_LSB +: $clog2(`TCB_BANK_N)];

  // stalled request pending
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      hold <= 1'b0;
    end else begin
      hold <= vld & ~rdy;
    end
  end

  // remember where the stalled request went
  always_ff @(posedge tcb) begin
    if (vld & ~rdy) begin
      hold_sel <= bank_sel;
    end
  end

  // vld may not wander to another bank mid handshake
  assign bank_sel = hold ? hold_sel : adr_sel;

  ////////////////////
  // fan out
  ////////////////////

  for (genvar i = 0; i < `TCB_BANK_N; i++) begin : g_bank
    // only the addressed bank sees vld
    assign bank[i].vld = vld & (bank_sel == bank_sel_t'(i));
    // rest of the request is broadcast
    assign bank[i].op  = op;
    assign bank[i].adr = adr;
    assign bank[i].ben = ben;
    assign bank[i].wdt = wdt;
    assign rdy_a[i]    = bank[i].rdy;
  end

  // ready of the selected bank
  assign rdy = rdy_a[bank_sel];

endmodule

//--- rtl/tcb_mem_bank.sv
/* TCB memory bank
   byte enabled storage, range error, refresh stall, fixed latency response */

`timescale 1ns/1ps

`include "tcb_defs.svh"

module tcb_mem_bank (
  input  logic tcb,
  input  logic rst_n,
  tcb_if.sub   bus
);

  import tcb_pkg::*;

  // byte offset bits below the word offset
  localparam int BYW = $clog2(`TCB_BEW);
  // word offset field in bits 11:2
  localparam int OFW = `TCB_BANK_SEL_LSB - BYW;
  // storage index width
  localparam int AW  = $clog2(`TCB_MEM_DEPTH);
  // bits per byte lane
  localparam int LNW = `TCB_DBW / `TCB_BEW;
  // refresh counter width
  localparam int CNW = $clog2(`TCB_REFRESH);

  ////////////////////
  // refresh fsm
  ////////////////////

  bank_state_t        state;
  bank_state_t        state_nxt;
  logic [CNW-1:0]     cnt;

  // free running so all banks stay in lockstep
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (cnt == CNW'(`TCB_REFRESH - 1)) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // refresh lands on the cycle where cnt is at its top value
  always_comb begin
    state_nxt = state;
    case (state)
      bank_run:     if (cnt == CNW'(`TCB_REFRESH - 2)) state_nxt = bank_refresh;
      bank_refresh: state_nxt = bank_run;
      default:      state_nxt = bank_run;
    endcase
  end

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      state <= bank_run;
    end else begin
      state <= state_nxt;
    end
  end

  // only back-pressure source
  assign bus.rdy = (state == bank_run);

  ////////////////////
  // storage
  ////////////////////

  tcb_dat_t       mem [`TCB_MEM_DEPTH];
  logic [OFW-1:0] off;
  logic [AW-1:0]  idx;
  logic           rng_err;

  assign off     = bus.adr[`TCB_BANK_SEL_LSB-1:BYW];
  assign idx     = off[AW-1:0];
  // offsets past the depth do not exist
  assign rng_err = (off >= OFW'(`TCB_MEM_DEPTH));

  // byte lane writes that skip errored transfers
  always_ff @(posedge tcb) begin
    if (bus.trn && (bus.op == op_write) && !rng_err) begin
      for (int b = 0; b < `TCB_BEW; b++) begin
        if (bus.ben[b]) begin
          mem[idx][b*LNW +: LNW] <= bus.wdt[b*LNW +: LNW];
        end
      end
    end
  end

  ////////////////////
  // response pipeline
  ////////////////////

  logic     pip_rsp [`TCB_DLY];
  tcb_dat_t pip_rdt [`TCB_DLY];
  logic     pip_err [`TCB_DLY];

  // transfer mark
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      pip_rsp[0] <= 1'b0;
    end else begin
      pip_rsp[0] <= bus.trn;
    end
  end

  // read data only moves on reads so writes keep the old word
  always_ff @(posedge tcb) begin
    if (bus.trn) begin
      pip_err[0] <= rng_err;
      if (bus.op == op_read) begin
        pip_rdt[0] <= mem[idx];
      end
    end
  end

  for (genvar i = 1; i < `TCB_DLY; i++) begin : g_pip
    always_ff @(posedge tcb or negedge rst_n) begin
      if (!rst_n) begin
        pip_rsp[i] <= 1'b0;
      end else begin
        pip_rsp[i] <= pip_rsp[i-1];
      end
    end

    always_ff @(posedge tcb) begin
      pip_rdt[i] <= pip_rdt[i-1];
      pip_err[i] <= pip_err[i-1];
    end
  end

  assign bus.rsp = pip_rsp[`TCB_DLY-1];
  assign bus.rdt = pip_rdt[`TCB_DLY-1];
  assign bus.err = pip_err[`TCB_DLY-1];

  ////////////////////
  // checks
  ////////////////////

  // fixed latency both ways, err travels with its transfer
  a_rsp_lat: assert property (@(posedge tcb) disable iff (!rst_n)
    (bus.trn |-> ##`TCB_DLY (bus.rsp && (bus.err == $past(rng_err, `TCB_DLY))))
    and (bus.rsp |-> $past(bus.trn, `TCB_DLY)))
    else $error("bank rsp or err wrong DLY cycles after trn");

  // one cycle stall at the top of the count
  a_rdy_gap: assert property (@(posedge tcb) disable iff (!rst_n)
    (!bus.rdy |-> (cnt == CNW'(`TCB_REFRESH - 1))) and (!bus.rdy |=> bus.rdy))
    else $error("bank rdy low off the refresh count or two cycles in a row");

endmodule

//--- rtl/tcb_rsp_mux.sv
/* TCB response multiplexer
   delays the bank select by DLY and returns the selected bank's response */

`timescale 1ns/1ps

`include "tcb_defs.svh"

module tcb_rsp_mux (
  input  logic               tcb,
  input  logic               rst_n,
  // transfer at the manager port
  input  logic               trn,
  input  tcb_pkg::bank_sel_t bank_sel,
  // banks, observed only
  tcb_if.mon                 bank [`TCB_BANK_N],
  // manager response
  output logic               rsp,
  output tcb_pkg::tcb_dat_t  rdt,
  output logic               err
);

  import tcb_pkg::*;

  ////////////////////
  // select delay line
  ////////////////////

  bank_sel_t sel_pip [`TCB_DLY];

  // first stage captures the select of each transfer
  always_ff @(posedge tcb) begin
    if (trn) begin
      sel_pip[0] <= bank_sel;
    end
  end

  // then it walks along with the bank pipelines
  for (genvar i = 1; i < `TCB_DLY; i++) begin : g_sel
    always_ff @(posedge tcb) begin
      sel_pip[i] <= sel_pip[i-1];
    end
  end

  ////////////////////
  // response mux
  ////////////////////

  // flatten the interface array, it cannot take a variable index
  logic [`TCB_BANK_N-1:0] rsp_a;
  tcb_dat_t               rdt_a [`TCB_BANK_N];
  logic [`TCB_BANK_N-1:0] err_a;

  for (genvar i = 0; i < `TCB_BANK_N; i++) begin : g_bank
    assign rsp_a[i] = bank[i].rsp;
    assign rdt_a[i] = bank[i].rdt;
    assign err_a[i] = bank[i].err;
  end

  // at most one bank answers
  assign rsp = |rsp_a;
  assign rdt = rdt_a[sel_pip[`TCB_DLY-1]];
  assign err = err_a[sel_pip[`TCB_DLY-1]];

  // in order responses mean no overlap between banks
  a_rsp_one: assert property (@(posedge tcb) disable iff (!rst_n)
    $onehot0(rsp_a))
    else $error("more than one bank raised rsp");

endmodule

//--- rtl/tcb_mem_sys.sv
/* TCB memory subsystem top
   one manager port, decoder, generated banks and response mux */

`timescale 1ns/1ps

`include "tcb_defs.svh"

module tcb_mem_sys (
  input  logic              tcb,
  input  logic              rst_n,
  // request
  input  logic              vld,
  input  logic              wen,
  input  tcb_pkg::tcb_adr_t adr,
  input  tcb_pkg::tcb_ben_t ben,
  input  tcb_pkg::tcb_dat_t wdt,
  output logic              rdy,
  // response
  output logic              rsp,
  output tcb_pkg::tcb_dat_t rdt,
  output logic              err
);

  import tcb_pkg::*;

  ////////////////////
  // local signals
  ////////////////////

  // wen carries the opcode
  tcb_op_t   op;
  // manager side transfer
  logic      trn;
  bank_sel_t bank_sel;

  assign op  = tcb_op_t'(wen);
  assign trn = vld & rdy;

  // one bus per bank, shared by decoder, bank and mux
  tcb_if bus [`TCB_BANK_N] ();

  ////////////////////
  // instances
  ////////////////////

  tcb_dec dec0 (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .vld      (vld),
    .op       (op),
    .adr      (adr),
    .ben      (ben),
    .wdt      (wdt),
    .rdy      (rdy),
    .bank_sel (bank_sel),
    .bank     (bus)
  );

  for (genvar i = 0; i < `TCB_BANK_N; i++) begin : g_bank
    tcb_mem_bank bank0 (
      .tcb   (tcb),
      .rst_n (rst_n),
      .bus   (bus[i])
    );
  end

  tcb_rsp_mux mux0 (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .trn      (trn),
    .bank_sel (bank_sel),
    .bank     (bus),
    .rsp      (rsp),
    .rdt      (rdt),
    .err      (err)
  );

endmodule

//--- tb/tcb_mem_sys_tb.sv
/* TCB memory subsystem testbench
   reference memory, streamed stimulus and assertion based response checks */

`timescale 1ns/1ps

`include "tcb_defs.svh"

module tcb_mem_sys_tb;

  import tcb_pkg::*;

  // test words, slot i lives in bank i mod BANK_N
  localparam int TST_N   = 16;
  // alias bits start above the bank select
  localparam int ALS_LSB = `TCB_BANK_SEL_LSB + $clog2(`TCB_BANK_N);

  logic     tcb;
  logic     rst_n;
  logic     vld;
  logic     wen;
  tcb_adr_t adr;
  tcb_ben_t ben;
  tcb_dat_t wdt;
  logic     rdy;
  logic     rsp;
  tcb_dat_t rdt;
  logic     err;
  logic     trn;

  // one expected response
  typedef struct packed {
    logic     rd;
    logic     err;
    tcb_dat_t rdt;
  } exp_t;

  tcb_dat_t ref_mem [`TCB_BANK_N][`TCB_MEM_DEPTH];
  exp_t     exp_q [$];
  exp_t     head;
  int       q_cnt;
  int       trn_cnt;
  int       cyc;
  tcb_adr_t tst_adr [TST_N];

  tcb_mem_sys dut0 (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (vld),
    .wen   (wen),
    .adr   (adr),
    .ben   (ben),
    .wdt   (wdt),
    .rdy   (rdy),
    .rsp   (rsp),
    .rdt   (rdt),
    .err   (err)
  );

  assign trn = vld & rdy;

  // 100 ns period
  always #50 tcb = ~tcb;

  ////////////////////
  // reference model
  ////////////////////

  // cycles since reset release, same phase as the bank counters
  always @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // responses pop in order, transfers push
  always @(posedge tcb or negedge rst_n) begin : ref_model
    exp_t e;
    int   bk;
    int   off;
    if (!rst_n) begin
      exp_q.delete();
      head    <= '0;
      q_cnt   <= 0;
      trn_cnt <= 0;
    end else begin
      if (rsp && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (trn) begin
        bk    = int'(adr >> `TCB_BANK_SEL_LSB) % `TCB_BANK_N;
        // word offset within the bank window
        off   = int'(adr[`TCB_BANK_SEL_LSB-1:0]) / `TCB_BEW;
        e.rd  = !wen;
        e.err = (off >= `TCB_MEM_DEPTH);
        e.rdt = ref_mem[bk][off % `TCB_MEM_DEPTH];
        // errored writes never land
        if (wen && !e.err) begin
          for (int b = 0; b < `TCB_BEW; b++) begin
            if (ben[b]) begin
              ref_mem[bk][off][b*8 +: 8] = wdt[b*8 +: 8];
            end
          end
        end
        exp_q.push_back(e);
        trn_cnt <= trn_cnt + 1;
      end
      q_cnt <= exp_q.size();
      head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // exact latency, no response without a transfer
  a_rsp_lat: assert property (@(posedge tcb) disable iff (!rst_n)
    rsp == $past(trn, `TCB_DLY))
    else stop_fail($sformatf("ERR %0t: rsp not %0d cycles after trn", $time, `TCB_DLY));

  // read data against the reference word
  a_rsp_dat: assert property (@(posedge tcb) disable iff (!rst_n)
    rsp |-> (q_cnt != 0) && (!head.rd || head.err || rdt == head.rdt))
    else stop_fail($sformatf("ERR %0t: rdt %h, expected %h", $time,
                             $sampled(rdt), $sampled(head.rdt)));

  a_rsp_err: assert property (@(posedge tcb) disable iff (!rst_n)
    rsp |-> err == head.err)
    else stop_fail($sformatf("ERR %0t: err does not match the offset range", $time));

  // refresh stall lands on k*REFRESH-1 only
  a_rdy_ref: assert property (@(posedge tcb) disable iff (!rst_n)
    rdy == ((cyc % `TCB_REFRESH) != `TCB_REFRESH - 1))
    else stop_fail($sformatf("ERR %0t: rdy %b in cycle %0d", $time, $sampled(rdy),
                             $sampled(cyc)));

  // a held request goes through right after the stall
  a_rdy_hold: assert property (@(posedge tcb) disable iff (!rst_n)
    (vld && !rdy) |=> trn)
    else stop_fail($sformatf("ERR %0t: held request not taken after stall", $time));

  a_rsp_idle: assert property (@(posedge tcb) disable iff (!rst_n)
    (trn_cnt == 0) |-> !rsp)
    else stop_fail($sformatf("ERR %0t: rsp high before any transfer", $time));

  ////////////////////
  // stimulus
  ////////////////////

  task automatic stop_fail(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1);
  endtask

  // random word in bank bk, hi picks the offset window above the depth
  function automatic tcb_adr_t make_adr(input int bk, input int hi);
    int wrd;
    int als;
    wrd = hi * `TCB_MEM_DEPTH + int'($urandom_range(`TCB_MEM_DEPTH - 1));
    als = int'($urandom_range(3));
    return tcb_adr_t'((als << ALS_LSB) | (bk << `TCB_BANK_SEL_LSB) | (wrd * `TCB_BEW));
  endfunction

  // request stays up, next call streams straight on
  task automatic send(input logic w, input tcb_adr_t a, input tcb_ben_t b,
                      input tcb_dat_t d);
    int n;
    vld = 1'b1;
    wen = w;
    adr = a;
    ben = b;
    wdt = d;
    n   = 0;
    while (!rdy && n < 4) begin
      @(posedge tcb);
      #1;
      n++;
    end
    if (!rdy) begin
      stop_fail("timed out waiting for rdy on a held request");
    end else begin
      @(posedge tcb);
      #1;
    end
  endtask

  task automatic idle();
    vld = 1'b0;
    wen = 1'b0;
  endtask

  // wait for every outstanding response
  task automatic drain();
    int n;
    n = 0;
    while (q_cnt != 0 && n < 10) begin
      @(posedge tcb);
      #1;
      n++;
    end
    if (q_cnt != 0) begin
      stop_fail("timed out waiting for outstanding responses");
    end
  endtask

  initial begin : stim
    int       i;
    int       r;
    int       hi;
    tcb_adr_t err_adr;
    void'($urandom(32'he6c1_5919));
    tcb   = 1'b0;
    rst_n = 1'b0;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    ben   = '0;
    wdt   = '0;
    for (i = 0; i < TST_N; i++) begin
      tst_adr[i] = make_adr(i % `TCB_BANK_N, 0);
    end
    repeat (3) @(posedge tcb);
    #1;
    rst_n = 1'b1;
    // quiet bus, rsp must stay low
    repeat (4) @(posedge tcb);
    #1;
    // full words first so every later read is known
    for (i = 0; i < TST_N; i++) begin
      send(1'b1, tst_adr[i], '1, $urandom);
    end
    // random lanes merged on top
    for (i = 0; i < TST_N; i++) begin
      send(1'b1, tst_adr[i], tcb_ben_t'($urandom), $urandom);
    end
    // reads alternate banks, two rounds cross a refresh stall
    for (r = 0; r < 2; r++) begin
      for (i = 0; i < TST_N; i++) begin
        send(1'b0, tst_adr[i], '0, '0);
      end
    end
    idle();
    drain();
    // out of range offset aliases onto slot 0
    hi      = int'($urandom_range(15, 1));
    err_adr = tst_adr[0] | tcb_adr_t'(hi * `TCB_MEM_DEPTH * `TCB_BEW);
    send(1'b1, err_adr, '1, $urandom);
    send(1'b0, err_adr, '0, '0);
    send(1'b0, tst_adr[0], '0, '0);
    idle();
    drain();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- tcb_mem_sys.f
+incdir+rtl
rtl/tcb_pkg.sv
rtl/tcb_if.sv
rtl/tcb_dec.sv
rtl/tcb_mem_bank.sv
rtl/tcb_rsp_mux.sv
rtl/tcb_mem_sys.sv
tb/tcb_mem_sys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the TCB memory subsystem testbench with Verilator.
# Pass or fail comes from the pass line in the simulation log.

set -u

cd "$(dirname "$0")" || { echo "cannot enter project root"; exit 1; }

BUILD_LOG=build.log
SIM_LOG=sim.log
TOP=tcb_mem_sys_tb

if ! verilator --binary --timing --assert -Wno-fatal \
     -f tcb_mem_sys.f --top-module "$TOP" -o "$TOP" > "$BUILD_LOG" 2>&1; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "^Everything OK$" "$SIM_LOG"; then
  echo "simulation passed (exit status $sim_status)"
  exit 0
else
  echo "simulation failed (exit status $sim_status)"
  exit 1
fi
